// ==== hdl/riscv_macros.svh ====
`ifndef RISCV_MACROS_SVH
`define RISCV_MACROS_SVH

// datapath and instruction widths
`define XLEN 32
`define ILEN 32

// rv32i base opcodes handled by the decode stage
`define OP_R      7'd51   // register-register alu
`define OP_LOAD   7'd3    // lb/lh/lw/lbu/lhu
`define OP_IALU   7'd19   // register-immediate alu
`define OP_STORE  7'd35   // sb/sh/sw
`define OP_BRANCH 7'd99   // beq/bne/...
`define OP_JALR   7'd103  // jump register, i-format
`define OP_JAL    7'd111  // jump and link, j-format

// opcode field width
`define OPC_W 7

`endif

// ==== hdl/riscv_decode_pkg.sv ====
`default_nettype none

`include "riscv_macros.svh"

package riscv_decode_pkg;

    // writeback source select
    typedef enum logic [1:0] {
        RES_ALU = 2'd0,   // alu result
        RES_MEM = 2'd1,   // data memory read
        RES_PC4 = 2'd2    // link address for jumps
    } result_src_t;

    // immediate format select
    typedef enum logic [2:0] {
        IMM_I = 3'd0,     // loads, alu-imm, jalr
        IMM_S = 3'd1,     // stores
        IMM_B = 3'd2,     // branches
        IMM_J = 3'd3      // jal
    } imm_src_t;

    // coarse alu request from the main decoder
    typedef enum logic [2:0] {
        ALUOP_ADD   = 3'd0,   // address calc, jumps
        ALUOP_SUB   = 3'd1,   // branch compare
        ALUOP_FUNCT = 3'd2    // decided by funct3/funct7
    } alu_op_t;

    // resolved alu operation, funct3 order of rv32i
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_ctrl_t;

    // word handed over by the fetch side
    typedef struct packed {
        logic [`ILEN-1:0] instr;   // raw instruction
        logic             eq;      // branch condition from compare
    } fetch_word_t;

    // control word towards execute
    typedef struct packed {
        logic             pc_src;      // take branch/jump target
        result_src_t      result_src;  // writeback mux
        logic             mem_write;   // data memory write enable
        logic             alu_src;     // 1 = immediate operand
        imm_src_t         imm_src;     // immediate format
        logic             reg_write;   // register file write enable
        alu_ctrl_t        alu_ctrl;    // resolved alu operation
        logic [`XLEN-1:0] imm;         // sign-extended immediate
        logic             illegal;     // unsupported opcode
    } ctrl_word_t;

endpackage

`default_nettype wire

// ==== hdl/hs_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module hs_stage #(
    parameter type payload_t = logic
)(
    input  logic     clk,
    input  logic     reset,
    input  logic     in_req,     // upstream request, data stable while high
    output logic     in_ack,     // upstream acknowledge
    input  payload_t in_data,
    output logic     out_req,    // downstream request
    input  logic     out_ack,    // downstream acknowledge
    output payload_t out_data
);

    typedef enum logic [1:0] {
        ST_EMPTY,   // nothing held
        ST_FULL,    // payload held, out_req raised or about to be
        ST_ACKED    // sink took it, waiting for out_ack release
    } state_t;

    state_t   state;
    payload_t data_q;    // held payload
    logic     capture;   // take in_data this cycle

    assign capture  = (state == ST_EMPTY) && in_req && !in_ack;
    assign out_data = data_q;   // only changes in ST_EMPTY, so stable under out_req

    always_ff @(posedge clk) begin
        if (capture) begin
            data_q <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= ST_EMPTY;
            in_ack  <= 1'b0;
            out_req <= 1'b0;
        end else begin
            if (!in_req) begin
                in_ack <= 1'b0;                 // source released its req
            end
            case (state)
                ST_EMPTY: begin
                    if (capture) begin
                        in_ack <= 1'b1;         // ack the cycle after sampling
                        state  <= ST_FULL;
                    end
                end
                ST_FULL: begin
                    if (!out_req) begin
                        if (!out_ack) begin
                            out_req <= 1'b1;    // never rise over a stale ack
                        end
                    end else if (out_ack) begin
                        out_req <= 1'b0;        // sink has sampled
                        state   <= ST_ACKED;
                    end
                end
                ST_ACKED: begin
                    if (!out_ack) begin
                        state <= ST_EMPTY;      // four phases done
                    end
                end
                default: state <= ST_EMPTY;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/main_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "riscv_macros.svh"

module main_decoder
    import riscv_decode_pkg::*;
(
    input  logic [`OPC_W-1:0] opcode,     // instr[6:0]
    input  logic              eq,         // branch condition
    output logic              pc_src,     // 1 = redirect pc
    output result_src_t       result_src, // writeback source
    output logic              mem_write,  // store enable
    output logic              alu_src,    // 1 = immediate as operand b
    output imm_src_t          imm_src,    // immediate format
    output logic              reg_write,  // rd write enable
    output alu_op_t           alu_op,     // request to alu_decoder
    output logic              illegal     // opcode not supported
);

    always_comb begin
        // safe defaults, all enables off
        pc_src     = 1'b0;
        result_src = RES_ALU;
        mem_write  = 1'b0;
        alu_src    = 1'b0;
        imm_src    = IMM_I;
        reg_write  = 1'b0;
        alu_op     = ALUOP_ADD;
        illegal    = 1'b0;

        case (opcode)
            `OP_R: begin
                reg_write = 1'b1;          // rd <- rs1 op rs2
                alu_op    = ALUOP_FUNCT;
            end
            `OP_LOAD: begin
                result_src = RES_MEM;      // rd <- mem[rs1 + imm]
                alu_src    = 1'b1;
                imm_src    = IMM_I;
                reg_write  = 1'b1;
                alu_op     = ALUOP_ADD;
            end
            `OP_IALU: begin
                alu_src   = 1'b1;          // rd <- rs1 op imm
                imm_src   = IMM_I;
                reg_write = 1'b1;
                alu_op    = ALUOP_FUNCT;
            end
            `OP_STORE: begin
                mem_write = 1'b1;          // mem[rs1 + imm] <- rs2
                alu_src   = 1'b1;
                imm_src   = IMM_S;
                alu_op    = ALUOP_ADD;
            end
            `OP_BRANCH: begin
                pc_src  = eq;              // taken only on condition
                imm_src = IMM_B;
                alu_op  = ALUOP_SUB;       // rs1 - rs2 compare
            end
            `OP_JALR: begin
                pc_src     = 1'b1;         // pc <- rs1 + imm
                result_src = RES_PC4;
                alu_src    = 1'b1;
                imm_src    = IMM_I;        // jalr is i-format
                reg_write  = 1'b1;
                alu_op     = ALUOP_ADD;
            end
            `OP_JAL: begin
                pc_src     = 1'b1;         // pc <- pc + imm
                result_src = RES_PC4;
                alu_src    = 1'b1;
                imm_src    = IMM_J;
                reg_write  = 1'b1;
                alu_op     = ALUOP_ADD;    // alu idle, add keeps it defined
            end
            default: begin
                illegal = 1'b1;            // zero and all unlisted opcodes
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/alu_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_decoder
    import riscv_decode_pkg::*;
(
    input  alu_op_t    alu_op,    // from main_decoder
    input  logic [2:0] funct3,    // instr[14:12]
    input  logic       funct7_5,  // instr[30]
    input  logic       op_5,      // opcode bit 5, set for r-type
    output alu_ctrl_t  alu_ctrl
);

    always_comb begin
        alu_ctrl = ALU_ADD;
        case (alu_op)
            ALUOP_ADD: alu_ctrl = ALU_ADD;
            ALUOP_SUB: alu_ctrl = ALU_SUB;
            ALUOP_FUNCT: begin
                case (funct3)
                    3'd0: begin
                        // addi has no sub form, bit 30 there is immediate
                        if (op_5 && funct7_5) begin
                            alu_ctrl = ALU_SUB;
                        end else begin
                            alu_ctrl = ALU_ADD;
                        end
                    end
                    3'd1: alu_ctrl = ALU_SLL;
                    3'd2: alu_ctrl = ALU_SLT;
                    3'd3: alu_ctrl = ALU_SLTU;
                    3'd4: alu_ctrl = ALU_XOR;
                    3'd5: begin
                        if (funct7_5) begin
                            alu_ctrl = ALU_SRA;   // sra and srai
                        end else begin
                            alu_ctrl = ALU_SRL;
                        end
                    end
                    3'd6: alu_ctrl = ALU_OR;
                    3'd7: alu_ctrl = ALU_AND;
                    default: alu_ctrl = ALU_ADD;
                endcase
            end
            default: alu_ctrl = ALU_ADD;   // unused alu_op codes
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/imm_extend.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "riscv_macros.svh"

module imm_extend
    import riscv_decode_pkg::*;
(
    input  logic [31:7]       instr,    // opcode bits not needed
    input  imm_src_t          imm_src,  // format select
    output logic [`XLEN-1:0]  imm
);

    logic sign;   // all formats sign-extend from bit 31

    assign sign = instr[31];

    always_comb begin
        case (imm_src)
            IMM_I: imm = {{(`XLEN-12){sign}}, instr[31:20]};
            IMM_S: imm = {{(`XLEN-12){sign}}, instr[31:25], instr[11:7]};
            IMM_B: begin
                // bit 0 is always zero for branch offsets
                imm = {{(`XLEN-12){sign}}, instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            IMM_J: begin
                imm = {{(`XLEN-20){sign}}, instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            default: imm = '0;   // unused formats
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/decode_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "riscv_macros.svh"

module decode_unit
    import riscv_decode_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              in_req,      // fetch side request
    output logic              in_ack,
    input  logic [`ILEN-1:0]  in_instr,
    input  logic              in_eq,       // branch condition for this instr
    output logic              out_req,     // control word valid
    input  logic              out_ack,     // execute side acknowledge
    output logic              pc_src,
    output result_src_t       result_src,
    output logic              mem_write,
    output logic              alu_src,
    output imm_src_t          imm_src,
    output logic              reg_write,
    output alu_ctrl_t         alu_ctrl,
    output logic [`XLEN-1:0]  imm,
    output logic              illegal
);

    fetch_word_t fetch_in;   // packed from input ports
    fetch_word_t fetch_q;    // held by the input stage
    ctrl_word_t  ctrl_d;     // decoded from fetch_q
    ctrl_word_t  ctrl_q;     // held by the output stage
    logic        mid_req;    // internal link
    logic        mid_ack;
    alu_op_t     alu_op;     // main to alu decoder

    assign fetch_in.instr = in_instr;
    assign fetch_in.eq    = in_eq;

    hs_stage #(.payload_t(fetch_word_t)) u_in_stage (
        .clk(clk), .reset(reset),
        .in_req(in_req), .in_ack(in_ack), .in_data(fetch_in),
        .out_req(mid_req), .out_ack(mid_ack), .out_data(fetch_q)
    );

    main_decoder u_main_dec (
        .opcode(fetch_q.instr[6:0]), .eq(fetch_q.eq),
        .pc_src(ctrl_d.pc_src), .result_src(ctrl_d.result_src),
        .mem_write(ctrl_d.mem_write), .alu_src(ctrl_d.alu_src),
        .imm_src(ctrl_d.imm_src), .reg_write(ctrl_d.reg_write),
        .alu_op(alu_op), .illegal(ctrl_d.illegal)
    );

    alu_decoder u_alu_dec (
        .alu_op(alu_op), .funct3(fetch_q.instr[14:12]),
        .funct7_5(fetch_q.instr[30]), .op_5(fetch_q.instr[5]),
        .alu_ctrl(ctrl_d.alu_ctrl)
    );

    imm_extend u_imm_ext (
        .instr(fetch_q.instr[31:7]), .imm_src(ctrl_d.imm_src),
        .imm(ctrl_d.imm)
    );

    hs_stage #(.payload_t(ctrl_word_t)) u_out_stage (
        .clk(clk), .reset(reset),
        .in_req(mid_req), .in_ack(mid_ack), .in_data(ctrl_d),
        .out_req(out_req), .out_ack(out_ack), .out_data(ctrl_q)
    );

    // unpack held control word to loose ports
    assign pc_src     = ctrl_q.pc_src;
    assign result_src = ctrl_q.result_src;
    assign mem_write  = ctrl_q.mem_write;
    assign alu_src    = ctrl_q.alu_src;
    assign imm_src    = ctrl_q.imm_src;
    assign reg_write  = ctrl_q.reg_write;
    assign alu_ctrl   = ctrl_q.alu_ctrl;
    assign imm        = ctrl_q.imm;
    assign illegal    = ctrl_q.illegal;

endmodule

`default_nettype wire

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;     // 8 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (16) @(posedge clk);
        reset <= 1'b0;             // released on an edge, synchronous
    end

endmodule

`default_nettype wire

// ==== test/decode_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_assertions
    import riscv_decode_pkg::*;
(
    input logic                          clk,
    input logic                          reset,
    input logic                          in_req,
    input logic                          in_ack,
    input logic                          mid_req,
    input logic                          out_req,
    input logic                          out_ack,
    input logic [$bits(ctrl_word_t)-1:0] word   // control word as seen on the output ports
);

    int fails = 0;   // failed assertion count

    // output word must hold while the request is up
    word_stable: assert property (@(posedge clk) disable iff (reset)
        (out_req && $past(out_req)) |-> $stable(word))
        else begin
            $error("control word changed while out_req was high");
            fails++;
        end

    // a new request never starts over a stale acknowledge
    req_after_ack_low: assert property (@(posedge clk) disable iff (reset)
        $rose(out_req) |-> !$past(out_ack))
        else begin
            $error("out_req rose while out_ack was high");
            fails++;
        end

    // ack only answers a request
    ack_after_req: assert property (@(posedge clk) disable iff (reset)
        $rose(in_ack) |-> $past(in_req))
        else begin
            $error("in_ack rose without in_req");
            fails++;
        end

    // reset clears every handshake output
    reset_clears: assert property (@(posedge clk)
        reset |=> (!in_ack && !mid_req && !out_req))
        else begin
            $error("handshake outputs not low after reset");
            fails++;
        end

endmodule

bind decode_unit decode_assertions u_hs_chk (
    .clk(clk), .reset(reset),
    .in_req(in_req), .in_ack(in_ack), .mid_req(mid_req),
    .out_req(out_req), .out_ack(out_ack),
    .word({pc_src, result_src, mem_write, alu_src, imm_src, reg_write,
           alu_ctrl, imm, illegal})
);

`default_nettype wire

// ==== test/decode_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "riscv_macros.svh"

module decode_tb
    import riscv_decode_pkg::*;
;

    localparam int TMO = 200;       // cycles allowed per wait

    logic        clk, reset;
    logic        in_req, in_ack, in_eq, out_req, out_ack;
    logic [31:0] in_instr;
    logic        pc_src, mem_write, alu_src, reg_write, illegal;
    result_src_t result_src;
    imm_src_t    imm_src;
    alu_ctrl_t   alu_ctrl;
    logic [31:0] imm;

    logic [15:0] lfsr = 16'd36;     // seed
    int          errors = 0, timeouts = 0, checks = 0;
    logic        both_busy = 1'b0;  // two items seen in flight
    logic [31:0] instr_q[$];
    logic        eq_q[$];
    string       name_q[$];
    ctrl_word_t  exp_q[$];

    tb_clock u_clk (.clk(clk), .reset(reset));

    decode_unit uut (
        .clk(clk), .reset(reset),
        .in_req(in_req), .in_ack(in_ack), .in_instr(in_instr), .in_eq(in_eq),
        .out_req(out_req), .out_ack(out_ack),
        .pc_src(pc_src), .result_src(result_src), .mem_write(mem_write),
        .alu_src(alu_src), .imm_src(imm_src), .reg_write(reg_write),
        .alu_ctrl(alu_ctrl), .imm(imm), .illegal(illegal)
    );

    // fibonacci lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic get_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);   // one step per bit
            v = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic alu_ctrl_t alu_expect(logic [2:0] f3, logic b30, logic r_type);
        case (f3)
            3'd0: return (r_type && b30) ? ALU_SUB : ALU_ADD;  // addi has no sub
            3'd1: return ALU_SLL;
            3'd2: return ALU_SLT;
            3'd3: return ALU_SLTU;
            3'd4: return ALU_XOR;
            3'd5: return b30 ? ALU_SRA : ALU_SRL;
            3'd6: return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    // reference model built from the isa rules
    function automatic ctrl_word_t model(logic [31:0] ins, logic e);
        ctrl_word_t w;
        w = '0;
        case (ins[6:0])
            `OP_R: begin
                w.reg_write = 1'b1;
                w.alu_ctrl  = alu_expect(ins[14:12], ins[30], 1'b1);
            end
            `OP_IALU: begin
                w.alu_src = 1'b1;
                w.reg_write = 1'b1;
                w.alu_ctrl = alu_expect(ins[14:12], ins[30], 1'b0);
            end
            `OP_LOAD: begin
                w.result_src = RES_MEM;
                w.alu_src = 1'b1;
                w.reg_write = 1'b1;
            end
            `OP_STORE: begin
                w.mem_write = 1'b1;
                w.alu_src = 1'b1;
                w.imm_src = IMM_S;
            end
            `OP_BRANCH: begin
                w.pc_src = e;          // taken only when equal
                w.imm_src = IMM_B;
                w.alu_ctrl = ALU_SUB;
            end
            `OP_JALR, `OP_JAL: begin
                w.pc_src = 1'b1;
                w.result_src = RES_PC4;
                w.alu_src = 1'b1;
                w.reg_write = 1'b1;
                w.imm_src = (ins[6:0] == `OP_JAL) ? IMM_J : IMM_I;
            end
            default: w.illegal = 1'b1;
        endcase
        case (w.imm_src)
            IMM_S: w.imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            IMM_B: w.imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            IMM_J: w.imm = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            default: w.imm = {{20{ins[31]}}, ins[31:20]};
        endcase
        return w;
    endfunction

    task automatic add_item(input string name, input logic [31:0] ins, input logic e);
        instr_q.push_back(ins);
        eq_q.push_back(e);
        name_q.push_back(name);
        exp_q.push_back(model(ins, e));
    endtask

    task automatic check_field(input string name, input string field,
                               input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (exp == act) else begin
            $display("error %s %s expected %h actual %h", name, field, exp, act);
            errors++;
        end
    endtask

    task automatic build_items();
        logic [31:0] r;
        logic [31:0] op;
        for (int k = 0; k < 2; k++) begin          // r then i-alu
            for (int f = 0; f < 8; f++) begin
                for (int b = 0; b < 2; b++) begin
                    get_bits(32, r);
                    r[30] = b[0];
                    r[14:12] = f[2:0];
                    r[6:0] = (k == 0) ? `OP_R : `OP_IALU;
                    add_item(k == 0 ? "r_alu" : "i_alu", r, 1'b0);
                end
            end
        end
        for (int i = 0; i < 8; i++) begin
            get_bits(32, r);
            add_item("load", {r[31:7], `OP_LOAD}, 1'b0);
            get_bits(32, r);
            add_item("store", {r[31:7], `OP_STORE}, 1'b0);
        end
        for (int i = 0; i < 4; i++) begin
            get_bits(32, r);
            add_item("branch", {r[31:7], `OP_BRANCH}, i[0]);
            get_bits(32, r);
            add_item("jal", {r[31:7], `OP_JAL}, i[0]);
            get_bits(32, r);
            add_item("jalr", {r[31:7], `OP_JALR}, i[0]);
        end
        add_item("illegal", 32'd0, 1'b0);
        for (int i = 0; i < 8; i++) begin
            do begin
                get_bits(7, op);
            end while (op[6:0] inside {`OP_R, `OP_LOAD, `OP_IALU, `OP_STORE,
                                       `OP_BRANCH, `OP_JALR, `OP_JAL, 7'd0});
            get_bits(32, r);
            add_item("illegal", {r[31:7], op[6:0]}, r[0]);
        end
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (reset && n < TMO);
        if (reset) begin
            $display("timeout: reset was never released");
            timeouts++;
        end
    endtask

    task automatic send_all();
        int n;
        wait_reset_release();
        foreach (instr_q[i]) begin
            n = 0;
            while (in_ack && n < TMO) begin
                @(posedge clk);
                n++;
            end
            if (in_ack) begin
                $display("timeout: in_ack never dropped before item %0d", i);
                timeouts++;
            end
            in_req   <= 1'b1;
            in_instr <= instr_q[i];
            in_eq    <= eq_q[i];
            n = 0;
            do begin
                @(posedge clk);
                n++;
            end while (!in_ack && n < TMO);
            if (!in_ack) begin
                $display("timeout: decode unit never acknowledged item %0d", i);
                timeouts++;
            end
            in_req <= 1'b0;
        end
    endtask

    task automatic receive_all();
        int          n;
        logic [31:0] d;
        ctrl_word_t  e;
        string       name;
        wait_reset_release();
        for (int i = 0; i < instr_q.size(); i++) begin
            n = 0;
            while (!out_req && n < TMO) begin
                @(posedge clk);
                n++;
            end
            if (!out_req) begin
                $display("timeout: no control word came out for item %0d", i);
                timeouts++;
                break;
            end
            e = exp_q.pop_front();
            name = name_q[i];
            check_field(name, "pc_src", e.pc_src, pc_src);
            check_field(name, "result_src", e.result_src, result_src);
            check_field(name, "mem_write", e.mem_write, mem_write);
            check_field(name, "alu_src", e.alu_src, alu_src);
            check_field(name, "imm_src", e.imm_src, imm_src);
            check_field(name, "reg_write", e.reg_write, reg_write);
            check_field(name, "alu_ctrl", e.alu_ctrl, alu_ctrl);
            check_field(name, "imm", e.imm, imm);
            check_field(name, "illegal", e.illegal, illegal);
            get_bits(3, d);
            repeat (d) @(posedge clk);   // random back-pressure
            out_ack <= 1'b1;
            n = 0;
            do begin
                @(posedge clk);
                n++;
            end while (out_req && n < TMO);
            if (out_req) begin
                $display("timeout: out_req stayed high after out_ack");
                timeouts++;
            end
            out_ack <= 1'b0;
        end
    endtask

    always @(posedge clk) begin
        if (uut.mid_req && out_req) begin
            both_busy <= 1'b1;         // input stage full behind output stage
        end
    end

    initial begin
        in_req   = 1'b0;
        in_instr = '0;
        in_eq    = 1'b0;
        out_ack  = 1'b0;
        build_items();
        fork
            send_all();
            receive_all();
        join
        checks++;
        assert (both_busy) else begin
            $display("two items were never in flight at the same time");
            errors++;
        end
        checks++;
        assert (exp_q.size() == 0) else begin
            $display("%0d control words never arrived", exp_q.size());
            errors++;
        end
        $display("checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
                 checks, errors, timeouts, uut.u_hs_chk.fails);
        if (errors == 0 && timeouts == 0 && uut.u_hs_chk.fails == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+hdl
hdl/riscv_decode_pkg.sv
hdl/hs_stage.sv
hdl/main_decoder.sv
hdl/alu_decoder.sv
hdl/imm_extend.sv
hdl/decode_unit.sv
test/tb_clock.sv
test/decode_assertions.sv
test/decode_tb.sv

// ==== Makefile ====
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f compile.f --top-module decode_tb -Mdir obj_dir

run: compile
	./obj_dir/Vdecode_tb | tee /dev/stderr | grep -q "^Test OK$$"

clean:
	rm -rf obj_dir
